// File: design/noc_pkg.sv
`default_nettype none

package noc_pkg;

    // Stream data and flit payload share one width
    localparam int flit_data_width = 32;

    // Node address width
    localparam int addr_width = 4;

    // Unused high bits of a head flit data word
    localparam int hdr_pad_width = flit_data_width - 2 * addr_width;

    // One flit on a link is 35 bits
    typedef struct packed {
        logic                       valid;
        logic                       head;
        logic                       tail;
        logic [flit_data_width-1:0] data;
    } flit_t;

    // Layout of the data word in a head flit
    typedef struct packed {
        logic [addr_width-1:0]    dest_addr;
        logic [addr_width-1:0]    src_addr;
        logic [hdr_pad_width-1:0] pad;
    } head_hdr_t;

    // Packetizer FSM
    typedef enum logic [1:0] {
        st_idle,
        st_head,
        st_body,
        st_drop
    } pkt_state_e;

endpackage

`default_nettype wire

// File: design/stream_packetizer.sv
`timescale 1ns/1ps
`default_nettype none

module stream_packetizer
    import noc_pkg::*;
#(
    parameter int buffer_depth = 4,
    parameter int max_payload = 4
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       s_axis_tvalid,
    output logic                       s_axis_tready,
    input  logic [flit_data_width-1:0] s_axis_tdata,
    input  logic                       s_axis_tlast,
    input  logic [addr_width-1:0]      s_axis_tdest,
    input  logic [addr_width-1:0]      source_address,
    output flit_t                      flit_out,
    input  logic                       credit_in,
    output logic                       tx_error,
    output logic                       tx_packet_in_progress
);

    localparam int cnt_width = $clog2(buffer_depth + 1);
    localparam int beat_width = $clog2(max_payload + 1);

    pkt_state_e             state;
    logic [cnt_width-1:0]   credit_cnt;
    logic [beat_width-1:0]  beat_cnt;
    logic                   has_credit;
    logic                   send_head;
    logic                   send_body;
    logic                   at_limit;
    logic                   cut;
    head_hdr_t              hdr;

    assign has_credit = (credit_cnt != '0);
    assign at_limit = (beat_cnt == beat_width'(max_payload - 1));

    // Head leaves as soon as a beat is offered and the next hop has room
    assign send_head = (state == st_idle) && s_axis_tvalid && has_credit;
    assign send_body = (state == st_body) && s_axis_tvalid && has_credit;

    // Overlong packet gets a forced tail here
    assign cut = send_body && !s_axis_tlast && at_limit;

    always_comb begin
        case (state)
            st_body: s_axis_tready = has_credit;
            st_drop: s_axis_tready = 1'b1;
            default: s_axis_tready = 1'b0;
        endcase
    end

    always_comb begin
        hdr.dest_addr = s_axis_tdest;
        hdr.src_addr = source_address;
        hdr.pad = '0;
    end

    assign tx_packet_in_progress = (state != st_idle);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= st_idle;
            beat_cnt <= '0;
            tx_error <= 1'b0;
        end else begin
            tx_error <= cut;
            case (state)
                st_idle: begin
                    if (send_head) begin
                        state <= st_head;
                        beat_cnt <= '0;
                    end
                end
                // Head flit is on the link for this cycle
                st_head: state <= st_body;
                st_body: begin
                    if (send_body) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (s_axis_tlast) begin
                            state <= st_idle;
                        end else if (at_limit) begin
                            state <= st_drop;
                        end
                    end
                end
                st_drop: begin
                    if (s_axis_tvalid && s_axis_tlast) begin
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Downstream credits
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            credit_cnt <= cnt_width'(buffer_depth);
        end else begin
            case ({send_head || send_body, credit_in})
                2'b10: credit_cnt <= credit_cnt - 1'b1;
                2'b01: credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            flit_out <= '0;
        end else begin
            flit_out.valid <= send_head || send_body;
            if (send_head) begin
                flit_out.head <= 1'b1;
                flit_out.tail <= 1'b0;
                flit_out.data <= hdr;
            end else if (send_body) begin
                flit_out.head <= 1'b0;
                flit_out.tail <= s_axis_tlast || at_limit;
                flit_out.data <= s_axis_tdata;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/link_hop.sv
`timescale 1ns/1ps
`default_nettype none

module link_hop
    import noc_pkg::*;
#(
    parameter int buffer_depth = 4
) (
    input  logic  clk,
    input  logic  reset,
    input  flit_t flit_in,
    output logic  credit_out,
    output flit_t flit_out,
    input  logic  credit_in
);

    localparam int cnt_width = $clog2(buffer_depth + 1);
    localparam int ptr_width = (buffer_depth > 1) ? $clog2(buffer_depth) : 1;

    flit_t                 mem [buffer_depth];
    logic [ptr_width-1:0]  wr_ptr;
    logic [ptr_width-1:0]  rd_ptr;
    logic [cnt_width-1:0]  count;
    logic [cnt_width-1:0]  credit_cnt;
    logic                  push;
    logic                  pop;

    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        next_ptr = (ptr == ptr_width'(buffer_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // Upstream credits keep the FIFO from overflowing
    assign push = flit_in.valid;
    assign pop = (count != '0) && (credit_cnt != '0);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= flit_in;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            credit_cnt <= cnt_width'(buffer_depth);
            credit_out <= 1'b0;
            flit_out <= '0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
                flit_out <= mem[rd_ptr];
            end else begin
                flit_out.valid <= 1'b0;
            end
            // Slot freed, so hand a credit back upstream
            credit_out <= pop;
            case ({push, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            case ({pop, credit_in})
                2'b10: credit_cnt <= credit_cnt - 1'b1;
                2'b01: credit_cnt <= credit_cnt + 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/stream_depacketizer.sv
`timescale 1ns/1ps
`default_nettype none

module stream_depacketizer
    import noc_pkg::*;
#(
    parameter int buffer_depth = 4,
    parameter logic [addr_width-1:0] local_addr = 4'd5
) (
    input  logic                       clk,
    input  logic                       reset,
    input  flit_t                      flit_in,
    output logic                       credit_out,
    output logic                       m_axis_tvalid,
    input  logic                       m_axis_tready,
    output logic [flit_data_width-1:0] m_axis_tdata,
    output logic                       m_axis_tlast,
    output logic [addr_width-1:0]      m_axis_tdest,
    output logic                       rx_error
);

    localparam int cnt_width = $clog2(buffer_depth + 1);
    localparam int ptr_width = (buffer_depth > 1) ? $clog2(buffer_depth) : 1;

    flit_t                 mem [buffer_depth];
    logic [ptr_width-1:0]  wr_ptr;
    logic [ptr_width-1:0]  rd_ptr;
    logic [cnt_width-1:0]  count;
    flit_t                 front;
    head_hdr_t             front_hdr;
    logic                  not_empty;
    logic                  pop_head;
    logic                  deliver;
    logic                  discard;
    logic                  pop;
    logic                  keep;
    logic [addr_width-1:0] src_q;

    function automatic logic [ptr_width-1:0] next_ptr(input logic [ptr_width-1:0] ptr);
        next_ptr = (ptr == ptr_width'(buffer_depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign front = mem[rd_ptr];
    assign front_hdr = head_hdr_t'(front.data);
    assign not_empty = (count != '0);

    // Heads never reach the stream and payload goes out or is thrown away
    assign pop_head = not_empty && front.head;
    assign deliver = not_empty && !front.head && keep;
    assign discard = not_empty && !front.head && !keep;
    assign pop = pop_head || discard || (deliver && m_axis_tready);

    assign m_axis_tvalid = deliver;
    assign m_axis_tdata = front.data;
    assign m_axis_tlast = front.tail;
    assign m_axis_tdest = src_q;

    always_ff @(posedge clk) begin
        if (flit_in.valid) begin
            mem[wr_ptr] <= flit_in;
        end
        // Sender address becomes tdest for the whole packet
        if (pop_head) begin
            src_q <= front_hdr.src_addr;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
            keep <= 1'b0;
            rx_error <= 1'b0;
            credit_out <= 1'b0;
        end else begin
            if (flit_in.valid) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({flit_in.valid, pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
            if (pop_head) begin
                keep <= (front_hdr.dest_addr == local_addr);
            end
            rx_error <= pop_head && (front_hdr.dest_addr != local_addr);
            credit_out <= pop;
        end
    end

endmodule

`default_nettype wire

// File: design/noc_link_top.sv
`timescale 1ns/1ps
`default_nettype none

module noc_link_top
    import noc_pkg::*;
#(
    parameter int num_hops = 3,
    parameter int buffer_depth = 4,
    parameter int max_payload = 4,
    parameter logic [addr_width-1:0] local_addr = 4'd5
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       s_axis_tvalid,
    output logic                       s_axis_tready,
    input  logic [flit_data_width-1:0] s_axis_tdata,
    input  logic                       s_axis_tlast,
    input  logic [addr_width-1:0]      s_axis_tdest,
    input  logic [addr_width-1:0]      source_address,
    output logic                       m_axis_tvalid,
    input  logic                       m_axis_tready,
    output logic [flit_data_width-1:0] m_axis_tdata,
    output logic                       m_axis_tlast,
    output logic [addr_width-1:0]      m_axis_tdest,
    output logic                       tx_error,
    output logic                       tx_packet_in_progress,
    output logic                       rx_error
);

    // Link i runs from stage i to stage i+1 and its credit flows back on the same index
    flit_t link_flit [0:num_hops];
    logic  link_credit [0:num_hops];

    stream_packetizer #(
        .buffer_depth (buffer_depth),
        .max_payload  (max_payload)
    ) u_packetizer (
        .clk                   (clk),
        .reset                 (reset),
        .s_axis_tvalid         (s_axis_tvalid),
        .s_axis_tready         (s_axis_tready),
        .s_axis_tdata          (s_axis_tdata),
        .s_axis_tlast          (s_axis_tlast),
        .s_axis_tdest          (s_axis_tdest),
        .source_address        (source_address),
        .flit_out              (link_flit[0]),
        .credit_in             (link_credit[0]),
        .tx_error              (tx_error),
        .tx_packet_in_progress (tx_packet_in_progress)
    );

    for (genvar i = 0; i < num_hops; i++) begin : g_hop
        link_hop #(
            .buffer_depth (buffer_depth)
        ) u_hop (
            .clk        (clk),
            .reset      (reset),
            .flit_in    (link_flit[i]),
            .credit_out (link_credit[i]),
            .flit_out   (link_flit[i+1]),
            .credit_in  (link_credit[i+1])
        );
    end

    stream_depacketizer #(
        .buffer_depth (buffer_depth),
        .local_addr   (local_addr)
    ) u_depacketizer (
        .clk           (clk),
        .reset         (reset),
        .flit_in       (link_flit[num_hops]),
        .credit_out    (link_credit[num_hops]),
        .m_axis_tvalid (m_axis_tvalid),
        .m_axis_tready (m_axis_tready),
        .m_axis_tdata  (m_axis_tdata),
        .m_axis_tlast  (m_axis_tlast),
        .m_axis_tdest  (m_axis_tdest),
        .rx_error      (rx_error)
    );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic reset
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Release on a falling edge away from the flops
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// File: tb/noc_link_props.sv
`timescale 1ns/1ps
`default_nettype none

module noc_link_props
    import noc_pkg::*;
#(
    parameter int buffer_depth = 4,
    parameter int num_links = 4,
    parameter int cnt_width = $clog2(buffer_depth + 1)
) (
    input logic                                clk,
    input logic                                reset,
    input logic [num_links-1:0]                link_valid,
    input logic [num_links-1:0][cnt_width-1:0] credit_cnt,
    input logic                                m_axis_tvalid,
    input logic                                m_axis_tready,
    input logic [flit_data_width-1:0]          m_axis_tdata,
    input logic                                m_axis_tlast
);

    for (genvar k = 0; k < num_links; k++) begin : g_link
        // Flit on link k left its sender on the previous edge
        a_sent_with_credit: assert property (@(posedge clk) disable iff (reset)
            link_valid[k] |-> $past(credit_cnt[k]) != '0)
            else $error("link %0d carried a flit sent with no credit", k);

        a_credit_bound: assert property (@(posedge clk) disable iff (reset)
            credit_cnt[k] <= cnt_width'(buffer_depth))
            else $error("credit counter of link %0d above buffer depth", k);
    end

    // Stalled beat must not change
    a_stream_stable: assert property (@(posedge clk) disable iff (reset)
        m_axis_tvalid && !m_axis_tready |=> $stable(m_axis_tdata) && $stable(m_axis_tlast))
        else $error("m_axis beat changed while stalled");

endmodule

bind noc_link_top noc_link_props #(
    .buffer_depth (buffer_depth),
    .num_links    (4)
) u_props (
    .clk           (clk),
    .reset         (reset),
    .link_valid    ({link_flit[3].valid, link_flit[2].valid,
                     link_flit[1].valid, link_flit[0].valid}),
    .credit_cnt    ({g_hop[2].u_hop.credit_cnt, g_hop[1].u_hop.credit_cnt,
                     g_hop[0].u_hop.credit_cnt, u_packetizer.credit_cnt}),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .m_axis_tdata  (m_axis_tdata),
    .m_axis_tlast  (m_axis_tlast)
);

`default_nettype wire

// File: tb/noc_link_tb.sv
`timescale 1ns/1ps
`default_nettype none

module noc_link_tb
    import noc_pkg::*;
();

    localparam int max_beats = 100;
    localparam int max_payload = 4;
    localparam logic [addr_width-1:0] local_addr = 4'd5;

    logic                       clk;
    logic                       reset;
    logic                       s_axis_tvalid;
    logic                       s_axis_tready;
    logic [flit_data_width-1:0] s_axis_tdata;
    logic                       s_axis_tlast;
    logic [addr_width-1:0]      s_axis_tdest;
    logic [addr_width-1:0]      source_address;
    logic                       m_axis_tvalid;
    logic                       m_axis_tready;
    logic [flit_data_width-1:0] m_axis_tdata;
    logic                       m_axis_tlast;
    logic [addr_width-1:0]      m_axis_tdest;
    logic                       tx_error;
    logic                       tx_packet_in_progress;
    logic                       rx_error;

    // Three words per beat for dest, last and data
    logic [31:0]                words [3*max_beats];
    logic [addr_width-1:0]      beat_dest [max_beats];
    logic                       beat_last [max_beats];
    logic [flit_data_width-1:0] beat_data [max_beats];
    logic [addr_width-1:0]      beat_src [max_beats];
    // Expected beat as {tdest, tlast, tdata}
    logic [36:0]                expected_q [$];
    int                         num_beats;
    int                         idx;
    int                         errors;
    int                         exp_tx;
    int                         exp_rx;
    int                         tx_seen;
    int                         rx_seen;
    int                         cycles;
    int                         cycle_limit;
    integer                     seed;
    logic                       s_fire;
    logic                       timed_out;

    tb_clock_gen u_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    noc_link_top #(
        .num_hops     (3),
        .buffer_depth (4),
        .max_payload  (max_payload),
        .local_addr   (local_addr)
    ) UUT (
        .clk                   (clk),
        .reset                 (reset),
        .s_axis_tvalid         (s_axis_tvalid),
        .s_axis_tready         (s_axis_tready),
        .s_axis_tdata          (s_axis_tdata),
        .s_axis_tlast          (s_axis_tlast),
        .s_axis_tdest          (s_axis_tdest),
        .source_address        (source_address),
        .m_axis_tvalid         (m_axis_tvalid),
        .m_axis_tready         (m_axis_tready),
        .m_axis_tdata          (m_axis_tdata),
        .m_axis_tlast          (m_axis_tlast),
        .m_axis_tdest          (m_axis_tdest),
        .tx_error              (tx_error),
        .tx_packet_in_progress (tx_packet_in_progress),
        .rx_error              (rx_error)
    );

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic load_tests();
        int i;
        int pkt;
        int pos;
        logic [addr_width-1:0] pkt_dest;
        // Fill never looks like a valid dest column
        for (i = 0; i < 3 * max_beats; i++) begin
            words[i] = 32'hffff_0000 | 32'(i);
        end
        $readmemh("tb/noc_link_tests.txt", words);
        num_beats = 0;
        pkt = 0;
        pos = 0;
        pkt_dest = '0;
        while (num_beats < max_beats && words[3*num_beats] <= 32'd15) begin
            i = num_beats;
            beat_dest[i] = words[3*i][addr_width-1:0];
            beat_last[i] = words[3*i+1][0];
            beat_data[i] = words[3*i+2];
            if (pos == 0) begin
                pkt_dest = beat_dest[i];
            end
            beat_src[i] = addr_width'(pkt + 1);
            // Only the first max_payload beats of a local packet come out
            if (pkt_dest == local_addr && pos < max_payload) begin
                expected_q.push_back({beat_src[i], beat_last[i] || (pos == max_payload - 1),
                                      beat_data[i]});
            end
            if (pos == max_payload) begin
                exp_tx++;
            end
            if (beat_last[i]) begin
                if (pkt_dest != local_addr) begin
                    exp_rx++;
                end
                pkt++;
                pos = 0;
            end else begin
                pos++;
            end
            num_beats++;
        end
    endtask

    task automatic check_output_beat();
        logic [36:0] exp;
        if (expected_q.size() == 0) begin
            errors++;
            $display("Unexpected output beat at %0t with data %h", $time, m_axis_tdata);
        end else begin
            exp = expected_q.pop_front();
            check_value("m_axis_tdata", exp[31:0], m_axis_tdata);
            check_value("m_axis_tlast", 32'(exp[32]), 32'(m_axis_tlast));
            check_value("m_axis_tdest", 32'(exp[36:33]), 32'(m_axis_tdest));
        end
    endtask

    // Drive on a falling edge and note what transfers on the next rising edge
    task automatic step_cycle();
        logic [31:0] rand_word;
        logic        new_beat;
        @(negedge clk);
        cycles++;
        new_beat = (cycles == 1) || s_fire;
        if (s_fire) begin
            idx++;
        end
        if (idx < num_beats) begin
            s_axis_tvalid = 1'b1;
            s_axis_tdata = beat_data[idx];
            s_axis_tlast = beat_last[idx];
            s_axis_tdest = beat_dest[idx];
            source_address = beat_src[idx];
        end else begin
            s_axis_tvalid = 1'b0;
            s_axis_tlast = 1'b0;
        end
        rand_word = $random(seed);
        m_axis_tready = (rand_word[2:1] == 2'b00);
        s_fire = s_axis_tvalid && s_axis_tready;
        // Packetizer is idle when a new packet's first beat is offered
        if (new_beat && idx < num_beats && (idx == 0 || beat_last[idx-1])) begin
            check_value("s_axis_tready", 32'd0, 32'(s_axis_tready));
        end
        if (s_fire) begin
            check_value("tx_packet_in_progress", 32'd1, 32'(tx_packet_in_progress));
        end
        if (m_axis_tvalid && m_axis_tready) begin
            check_output_beat();
        end
        if (tx_error) begin
            tx_seen++;
        end
        if (rx_error) begin
            rx_seen++;
        end
        if (cycles >= cycle_limit) begin
            timed_out = 1'b1;
        end
    endtask

    initial begin
        seed = 32'h0cda6f30;
        s_axis_tvalid = 1'b0;
        s_axis_tdata = '0;
        s_axis_tlast = 1'b0;
        s_axis_tdest = '0;
        source_address = '0;
        m_axis_tready = 1'b0;
        {errors, exp_tx, exp_rx, tx_seen, rx_seen, cycles, idx} = '0;
        s_fire = 1'b0;
        timed_out = 1'b0;
        load_tests();
        cycle_limit = 40 * num_beats + 200;
        if (num_beats == 0) begin
            errors++;
            $display("No input beats were read from the tests file");
        end

        @(negedge reset);
        repeat (3) begin
            @(negedge clk);
            check_value("m_axis_tvalid", 32'd0, 32'(m_axis_tvalid));
            check_value("tx_error", 32'd0, 32'(tx_error));
            check_value("rx_error", 32'd0, 32'(rx_error));
            check_value("tx_packet_in_progress", 32'd0, 32'(tx_packet_in_progress));
        end

        while (!timed_out && !(idx == num_beats && expected_q.size() == 0 &&
                               tx_seen >= exp_tx && rx_seen >= exp_rx)) begin
            step_cycle();
        end
        // Idle tail catches late or repeated beats and pulses
        if (!timed_out) begin
            repeat (20) step_cycle();
            // Packetizer back in idle after the last packet
            check_value("tx_packet_in_progress", 32'd0, 32'(tx_packet_in_progress));
            check_value("s_axis_tready", 32'd0, 32'(s_axis_tready));
        end
        if (timed_out) begin
            errors++;
            $display("Timeout after %0d cycles with %0d of %0d beats sent", cycles, idx,
                     num_beats);
        end
        check_value("tx_error pulses", 32'(exp_tx), 32'(tx_seen));
        check_value("rx_error pulses", 32'(exp_rx), 32'(rx_seen));
        check_value("missing output beats", 32'd0, 32'(expected_q.size()));

        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/noc_link_tests.txt
// dest last data, one input beat per line, all hex
// dest is the node address, last is 1 on the final beat of a packet
5 0 11110001
5 0 11110002
5 1 11110003
3 0 22220001
3 1 22220002
5 0 33330001
5 0 33330002
5 0 33330003
5 0 33330004
5 0 33330005
5 1 33330006
5 1 44440001
5 0 55550001
5 0 55550002
5 0 55550003
5 1 55550004
9 0 66660001
9 0 66660002
9 0 66660003
9 0 66660004
9 1 66660005
5 0 77770001
5 0 77770002
5 1 77770003

// File: flist.f
design/noc_pkg.sv
design/stream_packetizer.sv
design/link_hop.sv
design/stream_depacketizer.sv
design/noc_link_top.sv
tb/tb_clock_gen.sv
tb/noc_link_props.sv
tb/noc_link_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := noc_link_tb
FLIST     := flist.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf $(OBJ_DIR)
